// File: core_pkg.sv
package core_pkg;

    // Architectural widths
    localparam int ADDR_W = 32;
    localparam int LEN_W  = 6;

    // Fetch geometry in bytes
    localparam int FETCH_BYTES = 32;
    localparam int LINE_BYTES  = 64;
    localparam int LINE_OFF_W  = $clog2(LINE_BYTES);

    // Default sizes that the frontend top overrides
    localparam int DEFAULT_FTQ_DEPTH    = 8;
    localparam int DEFAULT_COMMIT_WIDTH = 2;
    localparam int DEFAULT_IBUF_CREDITS = 4;

    // First fetch address out of reset
    localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_1000;

endpackage

// File: frontend_pkg.sv
package frontend_pkg;

    // Packet id field wide enough for queues up to 16 entries
    localparam int PKT_ID_W = 4;

    // Branch type reported by the backend
    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_COND = 2'd1,
        BR_JUMP = 2'd2
    } br_kind_e;

    // Beat of the block currently being fetched
    typedef enum logic {
        IFU_FIRST  = 1'b0,
        IFU_SECOND = 1'b1
    } ifu_state_e;

    // One predicted fetch block
    typedef struct packed {
        logic                            valid;
        logic [core_pkg::ADDR_W-1:0]     start_pc;
        logic [core_pkg::LEN_W-1:0]      length;
        logic                            is_cross_line;
        logic                            pred_taken;
        logic [core_pkg::ADDR_W-1:0]     next_pc;
    } ftq_block_t;

    // Outcome of the first committed lane
    typedef struct packed {
        br_kind_e                        br_kind;
        logic                            is_taken;
        logic [core_pkg::ADDR_W-1:0]     target;
    } commit_meta_t;

    // Predictor update record
    typedef struct packed {
        logic                            valid;
        logic [core_pkg::ADDR_W-1:0]     start_pc;
        br_kind_e                        br_kind;
        logic                            is_taken;
        logic [core_pkg::ADDR_W-1:0]     target;
        logic                            pred_taken;
    } bpu_train_t;

    // Fetch packet toward the instruction buffer
    typedef struct packed {
        logic                            valid;
        logic [core_pkg::ADDR_W-1:0]     pc;
        logic [core_pkg::LEN_W-1:0]      length;
        logic [PKT_ID_W-1:0]             ftq_id;
        logic                            last;
    } fetch_pkt_t;

endpackage

// File: bpu.sv
`timescale 1ns/1ps

module bpu (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush_i,
    input  logic [core_pkg::ADDR_W-1:0] flush_pc_i,
    input  logic                        full_i,
    input  frontend_pkg::bpu_train_t    train_i,
    output frontend_pkg::ftq_block_t    block_o
);
    import core_pkg::*;
    import frontend_pkg::*;

    localparam int ENTRIES   = 8;
    localparam int IDX_W     = $clog2(ENTRIES);
    localparam int BLK_OFF_W = $clog2(FETCH_BYTES);
    localparam int TAG_W     = ADDR_W - 2;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [ADDR_W-1:0] target;
        br_kind_e          kind;
        logic [1:0]        ctr;
    } btb_entry_t;

    btb_entry_t          btb_mem [ENTRIES];
    logic [ENTRIES-1:0]  btb_vld_q;

    logic [ADDR_W-1:0]   pc_q;
    logic                run_q;

    logic [IDX_W-1:0]    rd_idx;
    btb_entry_t          rd_entry;
    logic                rd_hit;
    logic                pred_taken;
    logic [LINE_OFF_W:0] line_end;

    logic [IDX_W-1:0]    wr_idx;
    btb_entry_t          wr_entry;
    logic                wr_hit;
    logic                wr_en;

    // Lookup indexed by block number and tagged by word address
    assign rd_idx     = pc_q[BLK_OFF_W +: IDX_W];
    assign rd_entry   = btb_mem[rd_idx];
    assign rd_hit     = btb_vld_q[rd_idx] && (rd_entry.tag == pc_q[ADDR_W-1:2]);
    assign pred_taken = rd_hit && (rd_entry.ctr[1] || (rd_entry.kind == BR_JUMP));

    // End of the block measured from the start of its line
    assign line_end = {1'b0, pc_q[LINE_OFF_W-1:0]} + (LINE_OFF_W+1)'(FETCH_BYTES);

    always_comb begin
        block_o.valid         = run_q && !full_i && !flush_i;
        block_o.start_pc      = pc_q;
        block_o.length        = LEN_W'(FETCH_BYTES);
        block_o.is_cross_line = line_end > (LINE_OFF_W+1)'(LINE_BYTES);
        block_o.pred_taken    = pred_taken;
        block_o.next_pc       = pred_taken ? rd_entry.target : pc_q + ADDR_W'(FETCH_BYTES);
    end

    // Predicted PC holds while the queue is full
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q  <= RESET_PC;
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (flush_i) begin
                pc_q <= flush_pc_i;
            end else if (block_o.valid) begin
                pc_q <= block_o.next_pc;
            end
        end
    end

    // Training port
    assign wr_idx = train_i.start_pc[BLK_OFF_W +: IDX_W];
    assign wr_hit = btb_vld_q[wr_idx] && (btb_mem[wr_idx].tag == train_i.start_pc[ADDR_W-1:2]);
    // New entries only for taken branches
    assign wr_en  = train_i.valid && (wr_hit || train_i.is_taken);

    always_comb begin
        wr_entry = btb_mem[wr_idx];
        if (wr_hit) begin
            // Saturating counter update
            if (train_i.is_taken && (wr_entry.ctr != 2'd3)) begin
                wr_entry.ctr = wr_entry.ctr + 2'd1;
            end else if (!train_i.is_taken && (wr_entry.ctr != 2'd0)) begin
                wr_entry.ctr = wr_entry.ctr - 2'd1;
            end
            if (train_i.is_taken) begin
                wr_entry.target = train_i.target;
            end
            wr_entry.kind = train_i.br_kind;
        end else begin
            wr_entry.tag    = train_i.start_pc[ADDR_W-1:2];
            wr_entry.target = train_i.target;
            wr_entry.kind   = train_i.br_kind;
            wr_entry.ctr    = 2'd2;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            btb_mem[wr_idx] <= wr_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            btb_vld_q <= '0;
        end else if (wr_en) begin
            btb_vld_q[wr_idx] <= 1'b1;
        end
    end

endmodule

// File: ftq.sv
`timescale 1ns/1ps

module ftq #(
    parameter int FTQ_DEPTH    = core_pkg::DEFAULT_FTQ_DEPTH,
    parameter int COMMIT_WIDTH = core_pkg::DEFAULT_COMMIT_WIDTH
) (
    input  logic                               clk,
    input  logic                               rst,
    input  frontend_pkg::ftq_block_t           block_i,
    output logic                               full_o,
    output frontend_pkg::ftq_block_t           head_o,
    output logic [frontend_pkg::PKT_ID_W-1:0]  head_id_o,
    input  logic                               accept_i,
    input  logic [COMMIT_WIDTH-1:0]            commit_mask_i,
    input  logic [$clog2(FTQ_DEPTH)-1:0]       commit_id_i,
    input  frontend_pkg::commit_meta_t         commit_meta_i,
    input  logic                               flush_i,
    input  logic [$clog2(FTQ_DEPTH)-1:0]       flush_id_i,
    output frontend_pkg::bpu_train_t           train_o
);
    import frontend_pkg::*;

    // Pointer arithmetic wraps, so the depth is a power of two
    localparam int ID_W  = $clog2(FTQ_DEPTH);
    localparam int CNT_W = $clog2(COMMIT_WIDTH + 1);

    ftq_block_t           q_mem [FTQ_DEPTH];
    logic [FTQ_DEPTH-1:0] vld_q;
    logic [FTQ_DEPTH-1:0] vld_d;

    logic [ID_W-1:0]      bpu_ptr_q;
    logic [ID_W-1:0]      ifu_ptr_q;
    logic [ID_W-1:0]      comm_ptr_q;
    logic [ID_W-1:0]      bpu_ptr_inc;
    logic [ID_W-1:0]      keep_span;
    logic [CNT_W-1:0]     commit_num;

    logic                 train_hit;
    logic                 train_vld_q;
    bpu_train_t           train_data_q;

    // Number of lanes committed this cycle
    always_comb begin
        commit_num = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            commit_num = commit_num + CNT_W'(commit_mask_i[i]);
        end
    end

    // Entries from the commit pointer up to the flush id survive a flush
    assign keep_span = flush_id_i - comm_ptr_q;

    always_comb begin
        vld_d = vld_q;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (i < commit_num) begin
                vld_d[comm_ptr_q + ID_W'(i)] = 1'b0;
            end
        end
        if (block_i.valid) begin
            vld_d[bpu_ptr_q] = 1'b1;
        end
        if (flush_i) begin
            for (int i = 0; i < FTQ_DEPTH; i++) begin
                if ((ID_W'(i) - comm_ptr_q) > keep_span) begin
                    vld_d[i] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q      <= '0;
            bpu_ptr_q  <= '0;
            ifu_ptr_q  <= '0;
            comm_ptr_q <= '0;
        end else begin
            vld_q      <= vld_d;
            // Older blocks may still commit during a flush
            comm_ptr_q <= comm_ptr_q + ID_W'(commit_num);
            if (flush_i) begin
                bpu_ptr_q <= flush_id_i + 1'b1;
                ifu_ptr_q <= flush_id_i + 1'b1;
            end else begin
                if (block_i.valid) begin
                    bpu_ptr_q <= bpu_ptr_inc;
                end
                if (accept_i) begin
                    ifu_ptr_q <= ifu_ptr_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (block_i.valid) begin
            q_mem[bpu_ptr_q] <= block_i;
        end
    end

    // Head of the fetch side
    always_comb begin
        head_o       = q_mem[ifu_ptr_q];
        head_o.valid = vld_q[ifu_ptr_q];
    end

    assign head_id_o   = PKT_ID_W'(ifu_ptr_q);
    assign bpu_ptr_inc = bpu_ptr_q + 1'b1;
    // One slot stays empty to tell full from empty
    assign full_o      = (bpu_ptr_inc == comm_ptr_q);

    // Training record from the first committed lane
    assign train_hit = commit_mask_i[0] && (commit_meta_i.br_kind != BR_NONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            train_vld_q <= 1'b0;
        end else begin
            train_vld_q <= train_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (train_hit) begin
            train_data_q.valid      <= 1'b1;
            train_data_q.start_pc   <= q_mem[commit_id_i].start_pc;
            train_data_q.br_kind    <= commit_meta_i.br_kind;
            train_data_q.is_taken   <= commit_meta_i.is_taken;
            train_data_q.target     <= commit_meta_i.target;
            train_data_q.pred_taken <= q_mem[commit_id_i].pred_taken;
        end
    end

    always_comb begin
        train_o       = train_data_q;
        train_o.valid = train_vld_q;
    end

endmodule

// File: ifu.sv
`timescale 1ns/1ps

module ifu #(
    parameter int IBUF_CREDITS = core_pkg::DEFAULT_IBUF_CREDITS
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               flush_i,
    input  frontend_pkg::ftq_block_t           head_i,
    input  logic [frontend_pkg::PKT_ID_W-1:0]  head_id_i,
    output logic                               accept_o,
    input  logic                               credit_return_i,
    output frontend_pkg::fetch_pkt_t           pkt_o
);
    import core_pkg::*;
    import frontend_pkg::*;

    localparam int CRED_W = $clog2(IBUF_CREDITS + 1);

    ifu_state_e            state_q;
    logic [CRED_W-1:0]     credit_q;

    logic [LINE_OFF_W-1:0] line_off;
    logic [LEN_W-1:0]      first_len;
    logic [ADDR_W-1:0]     next_line_pc;
    logic [ADDR_W-1:0]     beat_pc;
    logic [LEN_W-1:0]      beat_len;
    logic                  beat_last;
    logic                  issue;

    logic                  pkt_vld_q;
    fetch_pkt_t            pkt_data_q;

    // Bytes up to the line boundary matter only for crossing blocks
    assign line_off     = head_i.start_pc[LINE_OFF_W-1:0];
    assign first_len    = LEN_W'(LINE_BYTES - int'(line_off));
    assign next_line_pc = {head_i.start_pc[ADDR_W-1:LINE_OFF_W] + 1'b1, {LINE_OFF_W{1'b0}}};

    always_comb begin
        if (state_q == IFU_SECOND) begin
            beat_pc   = next_line_pc;
            beat_len  = head_i.length - first_len;
            beat_last = 1'b1;
        end else begin
            beat_pc   = head_i.start_pc;
            beat_len  = head_i.is_cross_line ? first_len : head_i.length;
            beat_last = !head_i.is_cross_line;
        end
    end

    // No beat without a free buffer slot
    assign issue    = head_i.valid && (credit_q != '0) && !flush_i;
    assign accept_o = issue && beat_last;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            state_q <= IFU_FIRST;
        end else if (issue) begin
            state_q <= beat_last ? IFU_FIRST : IFU_SECOND;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_q <= CRED_W'(IBUF_CREDITS);
        end else begin
            credit_q <= credit_q + CRED_W'(credit_return_i) - CRED_W'(issue);
        end
    end

    // Registered packet output
    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_vld_q <= 1'b0;
        end else begin
            pkt_vld_q <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            pkt_data_q.valid  <= 1'b1;
            pkt_data_q.pc     <= beat_pc;
            pkt_data_q.length <= beat_len;
            pkt_data_q.ftq_id <= head_id_i;
            pkt_data_q.last   <= beat_last;
        end
    end

    always_comb begin
        pkt_o       = pkt_data_q;
        pkt_o.valid = pkt_vld_q;
    end

endmodule

// File: frontend_top.sv
`timescale 1ns/1ps

module frontend_top #(
    parameter int FTQ_DEPTH    = core_pkg::DEFAULT_FTQ_DEPTH,
    parameter int COMMIT_WIDTH = core_pkg::DEFAULT_COMMIT_WIDTH,
    parameter int IBUF_CREDITS = core_pkg::DEFAULT_IBUF_CREDITS
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [COMMIT_WIDTH-1:0]       commit_mask_i,
    input  logic [$clog2(FTQ_DEPTH)-1:0]  commit_id_i,
    input  frontend_pkg::commit_meta_t    commit_meta_i,
    input  logic                          flush_i,
    input  logic [$clog2(FTQ_DEPTH)-1:0]  flush_id_i,
    input  logic [core_pkg::ADDR_W-1:0]   flush_pc_i,
    input  logic                          credit_return_i,
    output frontend_pkg::fetch_pkt_t      pkt_o
);
    import frontend_pkg::*;

    ftq_block_t          bpu_block;
    logic                ftq_full;
    ftq_block_t          ftq_head;
    logic [PKT_ID_W-1:0] ftq_head_id;
    logic                ifu_accept;
    bpu_train_t          bpu_train;

    bpu u_bpu (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (flush_i),
        .flush_pc_i (flush_pc_i),
        .full_i     (ftq_full),
        .train_i    (bpu_train),
        .block_o    (bpu_block)
    );

    ftq #(
        .FTQ_DEPTH    (FTQ_DEPTH),
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) u_ftq (
        .clk           (clk),
        .rst           (rst),
        .block_i       (bpu_block),
        .full_o        (ftq_full),
        .head_o        (ftq_head),
        .head_id_o     (ftq_head_id),
        .accept_i      (ifu_accept),
        .commit_mask_i (commit_mask_i),
        .commit_id_i   (commit_id_i),
        .commit_meta_i (commit_meta_i),
        .flush_i       (flush_i),
        .flush_id_i    (flush_id_i),
        .train_o       (bpu_train)
    );

    ifu #(
        .IBUF_CREDITS (IBUF_CREDITS)
    ) u_ifu (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (flush_i),
        .head_i          (ftq_head),
        .head_id_i       (ftq_head_id),
        .accept_o        (ifu_accept),
        .credit_return_i (credit_return_i),
        .pkt_o           (pkt_o)
    );

endmodule

// File: frontend_assert.sv
`timescale 1ns/1ps

module frontend_assert #(
    parameter int IBUF_CREDITS = core_pkg::DEFAULT_IBUF_CREDITS
) (
    input logic                     clk,
    input logic                     rst,
    input logic                     flush_i,
    input logic                     credit_return_i,
    input frontend_pkg::fetch_pkt_t pkt_i
);
    import core_pkg::*;

    int unsigned       err_cnt;
    int                outstanding_q;
    logic              half_q;
    logic [ADDR_W-1:0] half_pc_q;
    logic [LEN_W-1:0]  half_len_q;

    initial err_cnt = 0;

    // Packets sitting in the instruction buffer
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding_q <= 0;
        end else begin
            outstanding_q <= outstanding_q + int'(pkt_i.valid) - int'(credit_return_i);
        end
    end

    // First beat of a split block waiting for its partner
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            half_q <= 1'b0;
        end else if (pkt_i.valid) begin
            half_q     <= !pkt_i.last;
            half_pc_q  <= pkt_i.pc;
            half_len_q <= pkt_i.length;
        end
    end

    a_reset_idle: assert property (@(posedge clk) rst |=> !pkt_i.valid)
        else begin
            err_cnt++;
            $error("fetch packet valid right after reset");
        end

    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        outstanding_q <= IBUF_CREDITS)
        else begin
            err_cnt++;
            $error("outstanding packets %0d above the credit limit", outstanding_q);
        end

    a_pkt_fields: assert property (@(posedge clk) disable iff (rst)
        pkt_i.valid |-> (pkt_i.length != 0) && (pkt_i.length <= FETCH_BYTES))
        else begin
            err_cnt++;
            $error("packet length out of range");
        end

    // A non-last beat always ends on the line boundary
    a_first_beat: assert property (@(posedge clk) disable iff (rst)
        pkt_i.valid && !pkt_i.last |-> (pkt_i.pc % LINE_BYTES) + pkt_i.length == LINE_BYTES)
        else begin
            err_cnt++;
            $error("first beat does not end at the line boundary");
        end

    a_second_beat: assert property (@(posedge clk) disable iff (rst)
        pkt_i.valid && half_q |-> pkt_i.last
            && (pkt_i.pc == ((half_pc_q | ADDR_W'(LINE_BYTES - 1)) + 1))
            && (half_len_q + pkt_i.length == FETCH_BYTES))
        else begin
            err_cnt++;
            $error("second beat does not complete the split block");
        end

endmodule

// File: tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;
    import core_pkg::*;
    import frontend_pkg::*;

    localparam int FTQ_DEPTH    = DEFAULT_FTQ_DEPTH;
    localparam int COMMIT_WIDTH = DEFAULT_COMMIT_WIDTH;
    localparam int IBUF_CREDITS = DEFAULT_IBUF_CREDITS;
    localparam int ID_W         = $clog2(FTQ_DEPTH);
    localparam int WAIT_LIMIT   = 300;
    localparam logic [ADDR_W-1:0] TRAIN_TGT = 32'h0000_8000;

    logic                    clk;
    logic                    rst;
    logic [COMMIT_WIDTH-1:0] commit_mask;
    logic [ID_W-1:0]         commit_id;
    commit_meta_t            commit_meta;
    logic                    flush;
    logic [ID_W-1:0]         flush_id;
    logic [ADDR_W-1:0]       flush_pc;
    logic                    credit_return;
    fetch_pkt_t              pkt;

    // Instruction buffer and backend state
    int                pkt_cnt;
    int                ibuf_cnt;
    bit                credit_en;
    logic [ID_W-1:0]   pend_id [$];
    logic [ADDR_W-1:0] pend_pc [$];

    // Expected packet stream
    logic [ADDR_W-1:0] exp_pc;
    logic [ID_W-1:0]   exp_id;
    logic [ADDR_W-1:0] beat2_pc;
    logic [LEN_W-1:0]  beat2_len;
    bit                beat2_due;
    int                split_cnt;
    logic [ADDR_W-1:0] prev_blk_pc;

    // Trained branch and the block seen right after it
    bit                trained;
    logic [ADDR_W-1:0] br_pc;
    logic [ADDR_W-1:0] follow_pc;
    bit                follow_seen;

    int errors;
    int err_base;
    int tests_run;
    int tests_failed;

    frontend_top #(
        .FTQ_DEPTH    (FTQ_DEPTH),
        .COMMIT_WIDTH (COMMIT_WIDTH),
        .IBUF_CREDITS (IBUF_CREDITS)
    ) dut (
        .clk             (clk),
        .rst             (rst),
        .commit_mask_i   (commit_mask),
        .commit_id_i     (commit_id),
        .commit_meta_i   (commit_meta),
        .flush_i         (flush),
        .flush_id_i      (flush_id),
        .flush_pc_i      (flush_pc),
        .credit_return_i (credit_return),
        .pkt_o           (pkt)
    );

    bind frontend_top frontend_assert #(
        .IBUF_CREDITS (IBUF_CREDITS)
    ) u_assert (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (flush_i),
        .credit_return_i (credit_return_i),
        .pkt_i           (pkt_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, want);
        end
    endtask

    task automatic fail_msg(input string why);
        errors++;
        $display("ERROR: %s", why);
    endtask

    function automatic commit_meta_t none_meta();
        commit_meta_t m;
        m.br_kind  = BR_NONE;
        m.is_taken = 1'b0;
        m.target   = '0;
        return m;
    endfunction

    function automatic commit_meta_t taken_meta();
        commit_meta_t m;
        m.br_kind  = BR_COND;
        m.is_taken = 1'b1;
        m.target   = TRAIN_TGT;
        return m;
    endfunction

    // Untrained blocks fall through by one fetch width
    function automatic logic [ADDR_W-1:0] next_block_pc(input logic [ADDR_W-1:0] pc);
        if (trained && pc == br_pc) begin
            return TRAIN_TGT;
        end
        return pc + FETCH_BYTES;
    endfunction

    task automatic close_block(input logic [ADDR_W-1:0] pc);
        pend_id.push_back(exp_id);
        pend_pc.push_back(pc);
        prev_blk_pc = pc;
        exp_pc      = next_block_pc(pc);
        exp_id      = exp_id + 1'b1;
    endtask

    task automatic check_packet(input fetch_pkt_t p);
        int off;
        if (beat2_due) begin
            check_val("pkt_o.pc", p.pc, beat2_pc);
            check_val("pkt_o.ftq_id", p.ftq_id, exp_id);
            check_val("pkt_o.length", p.length, beat2_len);
            check_val("pkt_o.last", p.last, 1);
            beat2_due = 1'b0;
            split_cnt++;
            close_block(exp_pc);
        end else begin
            if (trained && prev_blk_pc == br_pc) begin
                follow_pc   = p.pc;
                follow_seen = 1'b1;
            end
            check_val("pkt_o.pc", p.pc, exp_pc);
            check_val("pkt_o.ftq_id", p.ftq_id, exp_id);
            off = int'(exp_pc % LINE_BYTES);
            if (off + FETCH_BYTES > LINE_BYTES) begin
                // First beat runs to the line end
                check_val("pkt_o.length", p.length, LINE_BYTES - off);
                check_val("pkt_o.last", p.last, 0);
                beat2_due = 1'b1;
                beat2_pc  = exp_pc - off + LINE_BYTES;
                beat2_len = LEN_W'(FETCH_BYTES - (LINE_BYTES - off));
            end else begin
                check_val("pkt_o.length", p.length, FETCH_BYTES);
                check_val("pkt_o.last", p.last, 1);
                close_block(exp_pc);
            end
        end
    endtask

    // One clock of the buffer and backend model
    task automatic step();
        @(negedge clk);
        commit_mask   = '0;
        flush         = 1'b0;
        credit_return = 1'b0;
        if (pkt.valid) begin
            pkt_cnt++;
            ibuf_cnt++;
            check_packet(pkt);
        end
        if (credit_en && ibuf_cnt > 0 && ($urandom % 4) != 0) begin
            credit_return = 1'b1;
            ibuf_cnt--;
        end
        // Newest finished block stays uncommitted as a flush point
        if (pend_id.size() > 1) begin
            commit_meta = (trained && pend_pc[0] == br_pc) ? taken_meta() : none_meta();
            commit_mask = COMMIT_WIDTH'(1);
            commit_id   = pend_id.pop_front();
            pend_pc.delete(0);
        end
    endtask

    task automatic wait_packets(input int n, input string what);
        int target;
        int cycles;
        target = pkt_cnt + n;
        cycles = 0;
        while (pkt_cnt < target && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
        end
        if (pkt_cnt < target) begin
            fail_msg({"timeout waiting for packets, ", what});
        end
    endtask

    // Hold credits back until the fetch port stops
    task automatic quiesce();
        int idle;
        int cycles;
        credit_en = 1'b0;
        idle      = 0;
        cycles    = 0;
        while (idle < 6 && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
            if (pkt.valid || pend_id.size() > 1) begin
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (idle < 6) begin
            fail_msg("fetch port did not go idle with credits held back");
        end
    endtask

    // Oldest block commits and becomes the flush point in the same cycle
    task automatic flush_to(input logic [ADDR_W-1:0] pc, input commit_meta_t meta);
        if (pend_id.size() != 1) begin
            fail_msg("no single uncommitted block to flush to");
        end else begin
            step();
            commit_mask = COMMIT_WIDTH'(1);
            commit_id   = pend_id[0];
            commit_meta = meta;
            flush       = 1'b1;
            flush_id    = pend_id[0];
            flush_pc    = pc;
            exp_pc      = pc;
            exp_id      = pend_id[0] + 1'b1;
            beat2_due   = 1'b0;
            prev_blk_pc = '1;
            pend_id.delete();
            pend_pc.delete();
        end
    endtask

    task automatic begin_test();
        err_base = errors + int'(dut.u_assert.err_cnt);
    endtask

    task automatic end_test(input string name);
        bit ok;
        ok = (errors + int'(dut.u_assert.err_cnt)) == err_base;
        tests_run++;
        if (!ok) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, name, ok ? "ok" : "failed");
    endtask

    initial begin
        int                cycles;
        int                start;
        int                split_base;
        logic [ADDR_W-1:0] p_train;

        void'($urandom(32'h2c6a_4774));
        rst           = 1'b1;
        commit_mask   = '0;
        commit_id     = '0;
        commit_meta   = none_meta();
        flush         = 1'b0;
        flush_id      = '0;
        flush_pc      = '0;
        credit_return = 1'b0;
        pkt_cnt       = 0;
        ibuf_cnt      = 0;
        credit_en     = 1'b1;
        exp_pc        = RESET_PC;
        exp_id        = '0;
        beat2_pc      = '0;
        beat2_len     = '0;
        beat2_due     = 1'b0;
        split_cnt     = 0;
        prev_blk_pc   = '1;
        trained       = 1'b0;
        br_pc         = '0;
        follow_pc     = '0;
        follow_seen   = 1'b0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        p_train       = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        begin_test();
        wait_packets(1, "first packet after reset");
        end_test("first packet at reset pc");

        begin_test();
        wait_packets(3 * FTQ_DEPTH, "in-order stream");
        end_test("sequential blocks and ids");

        begin_test();
        quiesce();
        check_val("outstanding packets", ibuf_cnt, IBUF_CREDITS);
        credit_en = 1'b1;
        wait_packets(IBUF_CREDITS + 2, "output after credits return");
        end_test("credit stall and resume");

        begin_test();
        quiesce();
        split_base = split_cnt;
        flush_to(32'h0000_2024, none_meta());
        credit_en = 1'b1;
        wait_packets(12, "line-crossing blocks");
        if (split_cnt - split_base < 3) begin
            fail_msg("too few line-crossing blocks seen");
        end
        end_test("line-crossing split");

        begin_test();
        quiesce();
        flush_to(32'h0000_3000, none_meta());
        credit_en = 1'b1;
        start     = pkt_cnt;
        cycles    = 0;
        while (pkt_cnt == start && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
        end
        if (pkt_cnt == start) begin
            fail_msg("no packet after flush");
        end else if (cycles < 3) begin
            fail_msg("packet after flush arrived within 3 cycles");
        end
        wait_packets(6, "stream after flush");
        end_test("flush redirect");

        begin_test();
        quiesce();
        if (pend_pc.size() > 0) begin
            p_train = pend_pc[0];
        end
        // First taken commit allocates the entry
        flush_to(32'h0000_4000, taken_meta());
        br_pc   = p_train;
        trained = 1'b1;
        credit_en = 1'b1;
        wait_packets(6, "stream after first training");
        // Refetch the branch so it commits taken a second time
        quiesce();
        flush_to(br_pc, none_meta());
        credit_en = 1'b1;
        wait_packets(8, "stream through trained branch");
        quiesce();
        follow_seen = 1'b0;
        flush_to(br_pc, none_meta());
        credit_en = 1'b1;
        cycles    = 0;
        while (!follow_seen && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
        end
        if (!follow_seen) begin
            fail_msg("no block after the trained branch");
        end else begin
            check_val("block start after trained pc", follow_pc, TRAIN_TGT);
        end
        end_test("branch training");

        $display("tests run %0d, tests failed %0d, check errors %0d, assertion errors %0d",
                 tests_run, tests_failed, errors, dut.u_assert.err_cnt);
        if (errors == 0 && dut.u_assert.err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: compile.f
core_pkg.sv
frontend_pkg.sv
bpu.sv
ftq.sv
ifu.sv
frontend_top.sv
frontend_assert.sv
tb_frontend.sv

// File: Bender.yml
package:
  name: frontend_ftq

sources:
  - core_pkg.sv
  - frontend_pkg.sv
  - bpu.sv
  - ftq.sv
  - ifu.sv
  - frontend_top.sv
  - target: test
    files:
      - frontend_assert.sv
      - tb_frontend.sv
